/* mem_pkg.sv */
package mem_pkg;

    // cpu side widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // transfer length, number of bytes minus one
    typedef logic [1:0] len_t;

    // one queued cpu request
    typedef struct packed {
        logic              is_read;
        len_t              len;
        logic [addr_w-1:0] addr;
        // zero for reads
        logic [data_w-1:0] wdata;
    } req_t;

    // command byte bases, length is added in the low two bits
    localparam logic [7:0] cmd_read_base  = 8'hC0;
    localparam logic [7:0] cmd_write_base = 8'h80;

endpackage

/* req_fifo.sv */
module req_fifo import mem_pkg::*; #(
    parameter int queue_depth = 2
) (
    input  logic c_re,
    input  logic rst,
    input  logic push,
    input  req_t push_req,
    input  logic pop,
    output req_t head_req,
    output logic not_empty
);

    localparam int ptr_w = $clog2(queue_depth);

    req_t             mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == (ptr_w + 1)'(queue_depth));
    assign do_pop    = pop && not_empty;
    // a full queue still accepts a push when the head leaves this cycle
    assign do_push   = push && (!full || do_pop);
    assign head_req  = mem[rd_ptr];

    always_ff @(posedge c_re) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge c_re or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* cpu_port.sv */
module cpu_port import mem_pkg::*; (
    input  logic              c_re,
    input  logic              rst,
    input  logic              cpu_rd,
    input  logic              cpu_wr,
    input  logic [addr_w-1:0] cpu_raddr,
    input  logic [addr_w-1:0] cpu_waddr,
    input  len_t              cpu_rlen,
    input  len_t              cpu_wlen,
    input  logic [data_w-1:0] cpu_wdata,
    input  logic              rd_done,
    input  logic              wr_done,
    output logic              cpu_rack,
    output logic              cpu_wack,
    output logic              push,
    output req_t              push_req
);

    logic rd_q;
    logic wr_q;
    logic rd_rise;
    logic wr_rise;
    // write that rose together with a read, pushed one cycle later
    logic wr_hold;
    logic sel_rd;
    logic sel_wr;

    assign rd_rise = cpu_rd && !rd_q;
    assign wr_rise = cpu_wr && !wr_q;
    assign sel_rd  = rd_rise;
    assign sel_wr  = !rd_rise && (wr_rise || wr_hold);

    always_ff @(posedge c_re or posedge rst) begin
        if (rst) begin
            rd_q     <= 1'b0;
            wr_q     <= 1'b0;
            wr_hold  <= 1'b0;
            push     <= 1'b0;
            cpu_rack <= 1'b0;
            cpu_wack <= 1'b0;
        end else begin
            rd_q <= cpu_rd;
            wr_q <= cpu_wr;
            push <= sel_rd || sel_wr;
            if (sel_rd && wr_rise) begin
                wr_hold <= 1'b1;
            end else if (sel_wr) begin
                wr_hold <= 1'b0;
            end
            // ack held until the strobe is seen low
            if (rd_done) begin
                cpu_rack <= 1'b1;
            end else if (!cpu_rd) begin
                cpu_rack <= 1'b0;
            end
            if (wr_done) begin
                cpu_wack <= 1'b1;
            end else if (!cpu_wr) begin
                cpu_wack <= 1'b0;
            end
        end
    end

    // cpu keeps address and data stable while its strobe is high
    always_ff @(posedge c_re) begin
        if (sel_rd) begin
            push_req <= '{is_read: 1'b1, len: cpu_rlen, addr: cpu_raddr, wdata: '0};
        end else if (sel_wr) begin
            push_req <= '{is_read: 1'b0, len: cpu_wlen, addr: cpu_waddr, wdata: cpu_wdata};
        end
    end

endmodule

/* link_strobe_ctrl.sv */
module link_strobe_ctrl (
    input  logic       c_re,
    input  logic       rst,
    input  logic       send_req,
    input  logic       recv_req,
    input  logic [7:0] tx_byte,
    input  logic       u_wa,
    input  logic       u_ra,
    output logic [7:0] u_dout,
    output logic       u_we,
    output logic       u_re
);

    logic send_pend;
    logic recv_pend;

    always_ff @(posedge c_re or posedge rst) begin
        if (rst) begin
            send_pend <= 1'b0;
            recv_pend <= 1'b0;
            u_dout    <= '0;
            u_we      <= 1'b0;
            u_re      <= 1'b0;
        end else begin
            u_we <= 1'b0;
            u_re <= 1'b0;
            // tx_byte stays put until the sequencer's next send
            if (send_req || send_pend) begin
                if (u_wa) begin
                    u_we      <= 1'b1;
                    u_dout    <= tx_byte;
                    send_pend <= 1'b0;
                end else begin
                    send_pend <= 1'b1;
                end
            end
            if (recv_req || recv_pend) begin
                if (u_ra) begin
                    u_re      <= 1'b1;
                    recv_pend <= 1'b0;
                end else begin
                    recv_pend <= 1'b1;
                end
            end
        end
    end

endmodule

/* link_sequencer.sv */
module link_sequencer import mem_pkg::*; (
    input  logic              c_re,
    input  logic              rst,
    input  logic              not_empty,
    input  req_t              head_req,
    input  logic              u_wack,
    input  logic              u_rack,
    input  logic [7:0]        u_din,
    output logic              pop,
    output logic              send_req,
    output logic              recv_req,
    output logic [7:0]        tx_byte,
    output logic [data_w-1:0] cpu_rdata,
    output logic              rd_done,
    output logic              wr_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_cmd,
        st_addr,
        st_wdata,
        st_rdata
    } state_t;

    state_t     state;
    req_t       cur_req;
    // byte index within the address or data part
    logic [2:0] idx;
    logic [2:0] last;

    // low seven bits of octet k
    function automatic logic [7:0] seg_byte(input logic [31:0] word, input logic [1:0] k);
        return {1'b0, word[{k, 3'b000} +: 7]};
    endfunction

    // top bits of octets 0..len, bit k for octet k
    function automatic logic [7:0] top_byte(input logic [31:0] word, input len_t len);
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 4; i++) begin
            if (i <= int'(len)) begin
                b[i] = word[i*8+7];
            end
        end
        return b;
    endfunction

    function automatic logic [7:0] cmd_byte(input req_t r);
        return (r.is_read ? cmd_read_base : cmd_write_base) + 8'(r.len);
    endfunction

    assign pop  = (state == st_idle) && not_empty;
    assign last = {1'b0, cur_req.len};

    always_ff @(posedge c_re) begin
        if (pop) begin
            cur_req <= head_req;
        end
    end

    always_ff @(posedge c_re or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            idx       <= '0;
            send_req  <= 1'b0;
            recv_req  <= 1'b0;
            tx_byte   <= '0;
            cpu_rdata <= '0;
            rd_done   <= 1'b0;
            wr_done   <= 1'b0;
        end else begin
            send_req <= 1'b0;
            recv_req <= 1'b0;
            rd_done  <= 1'b0;
            wr_done  <= 1'b0;
            case (state)
                st_idle: begin
                    if (pop) begin
                        send_req <= 1'b1;
                        tx_byte  <= cmd_byte(head_req);
                        state    <= st_cmd;
                    end
                end
                st_cmd: begin
                    if (u_wack) begin
                        idx      <= '0;
                        send_req <= 1'b1;
                        tx_byte  <= seg_byte(cur_req.addr, 2'd0);
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (u_wack) begin
                        if (idx < 3'd3) begin
                            send_req <= 1'b1;
                            tx_byte  <= seg_byte(cur_req.addr, idx[1:0] + 2'd1);
                            idx      <= idx + 3'd1;
                        end else if (idx == 3'd3) begin
                            // all four address octets carry a top bit
                            send_req <= 1'b1;
                            tx_byte  <= top_byte(cur_req.addr, 2'd3);
                            idx      <= idx + 3'd1;
                        end else begin
                            idx <= '0;
                            if (cur_req.is_read) begin
                                cpu_rdata <= '0;
                                recv_req  <= 1'b1;
                                state     <= st_rdata;
                            end else begin
                                send_req <= 1'b1;
                                tx_byte  <= seg_byte(cur_req.wdata, 2'd0);
                                state    <= st_wdata;
                            end
                        end
                    end
                end
                st_wdata: begin
                    if (u_wack) begin
                        if (idx < last) begin
                            send_req <= 1'b1;
                            tx_byte  <= seg_byte(cur_req.wdata, idx[1:0] + 2'd1);
                            idx      <= idx + 3'd1;
                        end else if (idx == last) begin
                            send_req <= 1'b1;
                            tx_byte  <= top_byte(cur_req.wdata, cur_req.len);
                            idx      <= idx + 3'd1;
                        end else begin
                            wr_done <= 1'b1;
                            state   <= st_idle;
                        end
                    end
                end
                st_rdata: begin
                    if (u_rack) begin
                        // reply byte k lands in lane k
                        cpu_rdata[{idx[1:0], 3'b000} +: 8] <= u_din;
                        if (idx == last) begin
                            rd_done <= 1'b1;
                            state   <= st_idle;
                        end else begin
                            idx      <= idx + 3'd1;
                            recv_req <= 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* mem_uart_bridge.sv */
module mem_uart_bridge import mem_pkg::*; #(
    parameter int queue_depth = 2
) (
    input  logic              c_re,
    input  logic              rst,
    input  logic              cpu_rd,
    input  logic              cpu_wr,
    input  logic [addr_w-1:0] cpu_raddr,
    input  logic [addr_w-1:0] cpu_waddr,
    input  len_t              cpu_rlen,
    input  len_t              cpu_wlen,
    input  logic [data_w-1:0] cpu_wdata,
    output logic [data_w-1:0] cpu_rdata,
    output logic              cpu_rack,
    output logic              cpu_wack,
    input  logic [7:0]        u_din,
    output logic [7:0]        u_dout,
    output logic              u_re,
    output logic              u_we,
    input  logic              u_rack,
    input  logic              u_wack,
    input  logic              u_ra,
    input  logic              u_wa
);

    logic       push;
    req_t       push_req;
    logic       pop;
    req_t       head_req;
    logic       not_empty;
    logic       rd_done;
    logic       wr_done;
    logic       send_req;
    logic       recv_req;
    logic [7:0] tx_byte;

    cpu_port cpu_port0 (
        .c_re, .rst,
        .cpu_rd, .cpu_wr, .cpu_raddr, .cpu_waddr, .cpu_rlen, .cpu_wlen, .cpu_wdata,
        .rd_done, .wr_done,
        .cpu_rack, .cpu_wack, .push, .push_req
    );

    req_fifo #(.queue_depth(queue_depth)) req_fifo0 (
        .c_re, .rst, .push, .push_req, .pop, .head_req, .not_empty
    );

    link_sequencer link_sequencer0 (
        .c_re, .rst, .not_empty, .head_req, .u_wack, .u_rack, .u_din,
        .pop, .send_req, .recv_req, .tx_byte, .cpu_rdata, .rd_done, .wr_done
    );

    link_strobe_ctrl link_strobe_ctrl0 (
        .c_re, .rst, .send_req, .recv_req, .tx_byte, .u_wa, .u_ra,
        .u_dout, .u_we, .u_re
    );

endmodule

/* tb_checker.sv */
module tb_checker import mem_pkg::*; (
    input  logic              c_re,
    input  logic              rst,
    input  logic              cpu_rd,
    input  logic              cpu_wr,
    input  logic [addr_w-1:0] cpu_raddr,
    input  logic [addr_w-1:0] cpu_waddr,
    input  len_t              cpu_rlen,
    input  len_t              cpu_wlen,
    input  logic [data_w-1:0] cpu_wdata,
    input  logic [data_w-1:0] cpu_rdata,
    input  logic              cpu_rack,
    input  logic              cpu_wack,
    input  logic [7:0]        u_dout,
    input  logic              u_we,
    input  logic              u_re,
    input  logic              u_wa,
    input  logic              u_ra,
    output int                err_count,
    output int                check_count,
    output int                pending
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  exp_bytes [$];
    logic [31:0] exp_rdata [$];
    logic [7:0]  ref_mem [logic [31:0]];
    // reply bytes the sequencer still has to ask for
    int          rd_owed;
    logic        rd_q;
    logic        wr_q;
    logic        rack_q;
    logic        wa_q;
    logic        ra_q;
    logic [7:0]  exp_b;
    logic [31:0] exp_d;

    function automatic void note_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endfunction

    function automatic void note_fault(input string msg);
        $display("link protocol error at %0t ns: %s", $time, msg);
        err_count++;
    endfunction

    function automatic logic [7:0] ref_read(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a[7:0] ^ 8'h5a;
    endfunction

    // seven-bit segments of octets 0..n-1, then a byte of their top bits
    function automatic void push_octets(input logic [31:0] w, input int n);
        logic [7:0] top;
        int         k;
        top = 8'h00;
        for (k = 0; k < n; k++) begin
            exp_bytes.push_back({1'b0, w[k*8 +: 7]});
            top[k] = w[k*8+7];
        end
        exp_bytes.push_back(top);
    endfunction

    function automatic void expect_request(input logic is_read, input len_t len,
                                           input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        int          k;
        exp_bytes.push_back((is_read ? cmd_read_base : cmd_write_base) + 8'(len));
        push_octets(addr, 4);
        if (is_read) begin
            rd = '0;
            for (k = 0; k <= int'(len); k++) begin
                rd[k*8 +: 8] = ref_read(addr + 32'(k));
            end
            exp_rdata.push_back(rd);
            rd_owed += int'(len) + 1;
        end else begin
            push_octets(data, int'(len) + 1);
            for (k = 0; k <= int'(len); k++) begin
                ref_mem[addr + 32'(k)] = data[k*8 +: 8];
            end
        end
    endfunction

    // sampled at the rising edge before the DUT's registers update
    always @(posedge c_re) begin
        if (rst) begin
            exp_bytes.delete();
            exp_rdata.delete();
            ref_mem.delete();
            rd_owed     = 0;
            err_count   = 0;
            check_count = 0;
            pending     = 0;
            rd_q        = 1'b0;
            wr_q        = 1'b0;
            rack_q      = 1'b0;
            wa_q        = 1'b0;
            ra_q        = 1'b0;
        end else begin
            // read goes first when both strobes rise together
            if (cpu_rd && !rd_q) begin
                expect_request(1'b1, cpu_rlen, cpu_raddr, '0);
            end
            if (cpu_wr && !wr_q) begin
                expect_request(1'b0, cpu_wlen, cpu_waddr, cpu_wdata);
            end
            if (u_we) begin
                check_count++;
                if (!wa_q) begin
                    note_fault("u_we pulsed while u_wa was low");
                end
                if (exp_bytes.size() == 0) begin
                    note_fault($sformatf("unexpected u_we with byte %02h", u_dout));
                end else begin
                    exp_b = exp_bytes.pop_front();
                    if (u_dout !== exp_b) begin
                        note_mismatch($sformatf("u_dout %02h, expected %02h", u_dout, exp_b));
                    end
                end
            end
            if (u_re) begin
                if (!ra_q) begin
                    note_fault("u_re pulsed while u_ra was low");
                end
                if (rd_owed == 0) begin
                    note_fault("u_re pulsed with no read outstanding");
                end else begin
                    rd_owed--;
                end
            end
            // the ack rose one edge ago, so the strobe is judged at that edge
            if (cpu_rack && !rack_q) begin
                check_count++;
                if (!rd_q) begin
                    note_fault("cpu_rack rose while cpu_rd was low");
                end
                if (exp_rdata.size() == 0) begin
                    note_fault("cpu_rack rose with no read outstanding");
                end else begin
                    exp_d = exp_rdata.pop_front();
                    if (cpu_rdata !== exp_d) begin
                        note_mismatch($sformatf("cpu_rdata %08h, expected %08h",
                                                cpu_rdata, exp_d));
                    end
                end
            end
            // ack may linger for one cycle after the strobe falls
            if (cpu_wack && !cpu_wr && !wr_q) begin
                note_fault("cpu_wack still high a cycle after cpu_wr fell");
            end
            rd_q    = cpu_rd;
            wr_q    = cpu_wr;
            rack_q  = cpu_rack;
            wa_q    = u_wa;
            ra_q    = u_ra;
            pending = exp_bytes.size() + exp_rdata.size() + rd_owed;
        end
    end

endmodule

/* tb_mem_uart_bridge.sv */
module tb_mem_uart_bridge import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_entries      = 14;
    localparam int timeout_cycles = 2000;

    typedef struct packed {
        logic        is_read;
        logic        both;
        len_t        len;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
    } entry_t;

    logic              c_re;
    logic              rst;
    logic              cpu_rd;
    logic              cpu_wr;
    logic [addr_w-1:0] cpu_raddr;
    logic [addr_w-1:0] cpu_waddr;
    len_t              cpu_rlen;
    len_t              cpu_wlen;
    logic [data_w-1:0] cpu_wdata;
    logic [data_w-1:0] cpu_rdata;
    logic              cpu_rack;
    logic              cpu_wack;
    logic [7:0]        u_din;
    logic [7:0]        u_dout;
    logic              u_re;
    logic              u_we;
    logic              u_rack;
    logic              u_wack;
    logic              u_ra;
    logic              u_wa;

    entry_t      table_e [n_entries];
    logic [7:0]  mem_model [logic [31:0]];
    logic [7:0]  frame [11];
    int          fr_idx;
    logic [31:0] fr_addr;
    logic [31:0] rd_base;
    int          rd_k;
    logic [31:0] rnd_state;
    int          wa_stall;
    int          ra_stall;
    int          wack_wait;
    int          rack_wait;
    int          tb_errs;
    int          chk_errs;
    int          chk_count;
    int          chk_pending;

    mem_uart_bridge #(.queue_depth(2)) dut0 (.*);

    tb_checker chk0 (.*, .err_count(chk_errs), .check_count(chk_count), .pending(chk_pending));

    initial begin
        c_re = 1'b0;
        forever #10 c_re = ~c_re;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int stall_next(input int stall);
        rnd_state = lcg_next(rnd_state);
        if (stall != 0) begin
            return stall - 1;
        end
        if (rnd_state[19:16] == 4'h0) begin
            return 1 + int'(rnd_state[22:20]);
        end
        return 0;
    endfunction

    function automatic int ack_delay();
        rnd_state = lcg_next(rnd_state);
        return 1 + int'(rnd_state[25:24]);
    endfunction

    function automatic logic [7:0] model_read(input logic [31:0] a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a[7:0] ^ 8'h5a;
    endfunction

    // link side frame decoder, rebuilds each octet from segment and top bit
    function automatic void take_byte(input logic [7:0] b);
        len_t len;
        int   k;
        if (fr_idx < 11) begin
            frame[fr_idx] = b;
        end
        fr_idx++;
        len = frame[0][1:0];
        if (fr_idx == 6) begin
            for (k = 0; k < 4; k++) begin
                fr_addr[k*8 +: 8] = {frame[5][k], frame[1+k][6:0]};
            end
            if (frame[0][6]) begin
                rd_base = fr_addr;
                rd_k    = 0;
                fr_idx  = 0;
            end
        end else if (fr_idx == 8 + int'(len)) begin
            for (k = 0; k <= int'(len); k++) begin
                mem_model[fr_addr + 32'(k)] = {frame[7+int'(len)][k], frame[6+k][6:0]};
            end
            fr_idx = 0;
        end
    endfunction

    // link model, acts on the falling edge
    initial begin
        u_wa      = 1'b1;
        u_ra      = 1'b1;
        u_wack    = 1'b0;
        u_rack    = 1'b0;
        u_din     = 8'h00;
        rnd_state = 32'h271c;
        wa_stall  = 0;
        ra_stall  = 0;
        wack_wait = 0;
        rack_wait = 0;
        fr_idx    = 0;
        fr_addr   = '0;
        rd_base   = '0;
        rd_k      = 0;
        forever begin
            @(negedge c_re);
            u_wack = 1'b0;
            u_rack = 1'b0;
            if (!rst) begin
                wa_stall = stall_next(wa_stall);
                ra_stall = stall_next(ra_stall);
                u_wa     = (wa_stall == 0);
                u_ra     = (ra_stall == 0);
                if (wack_wait != 0) begin
                    wack_wait--;
                    u_wack = (wack_wait == 0);
                end
                if (u_we) begin
                    take_byte(u_dout);
                    wack_wait = ack_delay();
                end
                if (rack_wait != 0) begin
                    rack_wait--;
                    if (rack_wait == 0) begin
                        u_rack = 1'b1;
                        u_din  = model_read(rd_base + 32'(rd_k));
                        rd_k++;
                    end
                end
                if (u_re) begin
                    rack_wait = ack_delay();
                end
            end
        end
    end

    function automatic void set_entry(input int i, input logic rd, input logic both,
                                      input len_t len, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic [31:0] rdata);
        table_e[i].is_read = rd;
        table_e[i].both    = both;
        table_e[i].len     = len;
        table_e[i].addr    = addr;
        table_e[i].wdata   = wdata;
        table_e[i].rdata   = rdata;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_ack(input logic is_rd, input logic level, input string what);
        int n;
        n = 0;
        while ((is_rd ? cpu_rack : cpu_wack) !== level) begin
            @(negedge c_re);
            n++;
            if (n > timeout_cycles) begin
                abort_run({"timed out waiting for ", what});
            end
        end
    endtask

    task automatic run_entry(input entry_t e);
        @(negedge c_re);
        if (e.is_read || e.both) begin
            cpu_raddr = e.addr;
            cpu_rlen  = e.len;
            cpu_rd    = 1'b1;
        end
        if (!e.is_read || e.both) begin
            cpu_waddr = e.addr;
            cpu_wlen  = e.len;
            cpu_wdata = e.wdata;
            cpu_wr    = 1'b1;
        end
        if (cpu_rd) begin
            wait_ack(1'b1, 1'b1, "cpu_rack to rise");
            if (cpu_rdata !== e.rdata) begin
                tb_errs++;
                $display("ERR %0t: read %08h returned %08h, expected %08h",
                         $time, e.addr, cpu_rdata, e.rdata);
            end
            cpu_rd = 1'b0;
            wait_ack(1'b1, 1'b0, "cpu_rack to fall");
        end
        if (cpu_wr) begin
            wait_ack(1'b0, 1'b1, "cpu_wack to rise");
            cpu_wr = 1'b0;
            wait_ack(1'b0, 1'b0, "cpu_wack to fall");
        end
    endtask

    initial begin
        rst       = 1'b1;
        cpu_rd    = 1'b0;
        cpu_wr    = 1'b0;
        cpu_raddr = '0;
        cpu_waddr = '0;
        cpu_rlen  = '0;
        cpu_wlen  = '0;
        cpu_wdata = '0;
        tb_errs   = 0;
        // rdata column holds the expected read result, unused for writes
        set_entry(0, 1'b0, 1'b0, 2'd0, 32'h0000_0010, 32'h0000_00a5, 32'h0);
        set_entry(1, 1'b1, 1'b0, 2'd0, 32'h0000_0010, 32'h0, 32'h0000_00a5);
        set_entry(2, 1'b0, 1'b0, 2'd1, 32'h8040_2001, 32'h0000_f00d, 32'h0);
        set_entry(3, 1'b1, 1'b0, 2'd1, 32'h8040_2001, 32'h0, 32'h0000_f00d);
        set_entry(4, 1'b0, 1'b0, 2'd2, 32'h1234_5678, 32'h00c3_7e81, 32'h0);
        set_entry(5, 1'b1, 1'b0, 2'd2, 32'h1234_5678, 32'h0, 32'h00c3_7e81);
        set_entry(6, 1'b0, 1'b0, 2'd3, 32'hffff_ff00, 32'hdead_beef, 32'h0);
        set_entry(7, 1'b1, 1'b0, 2'd3, 32'hffff_ff00, 32'h0, 32'hdead_beef);
        set_entry(8, 1'b1, 1'b0, 2'd3, 32'h0000_0200, 32'h0, 32'h5958_5b5a);
        set_entry(9, 1'b1, 1'b0, 2'd0, 32'h7f80_81fe, 32'h0, 32'h0000_00a4);
        // both strobes at once, the read sees the old content
        set_entry(10, 1'b1, 1'b1, 2'd1, 32'h0000_0300, 32'h0000_9c3b, 32'h0000_5b5a);
        set_entry(11, 1'b1, 1'b0, 2'd1, 32'h0000_0300, 32'h0, 32'h0000_9c3b);
        set_entry(12, 1'b1, 1'b1, 2'd3, 32'ha5a5_0040, 32'h8001_7f80, 32'h1918_1b1a);
        set_entry(13, 1'b1, 1'b0, 2'd3, 32'ha5a5_0040, 32'h0, 32'h8001_7f80);
        repeat (2) @(negedge c_re);
        rst = 1'b0;
        // quiet after reset
        repeat (8) begin
            @(negedge c_re);
            if (u_we || u_re || cpu_rack || cpu_wack) begin
                tb_errs++;
                $display("ERR %0t: DUT output active with no request", $time);
            end
        end
        for (int i = 0; i < n_entries; i++) begin
            run_entry(table_e[i]);
        end
        repeat (4) @(negedge c_re);
        if (chk_pending != 0) begin
            tb_errs++;
            $display("ERR %0t: %0d expected link events never happened", $time, chk_pending);
        end
        $display("checks %0d, checker errors %0d, testbench errors %0d",
                 chk_count, chk_errs, tb_errs);
        if (chk_errs == 0 && tb_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* all.f */
mem_pkg.sv
req_fifo.sv
cpu_port.sv
link_strobe_ctrl.sv
link_sequencer.sv
mem_uart_bridge.sv
tb_checker.sv
tb_mem_uart_bridge.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_mem_uart_bridge
RTL_TOP   ?= mem_uart_bridge
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -x "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
